// ==== hw/memPkg.sv ====
package memPkg;

    localparam int xlen = 32;
    localparam int ramAddrWidth = 12;
    localparam int ramBytes = 1 << ramAddrWidth;
    localparam int instBytes = 4;

    typedef enum logic {
        opLoad,
        opStore
    } lsOp_t;

    // encoded as byte count minus one
    typedef enum logic [1:0] {
        widthByte = 2'd0,
        widthHalf = 2'd1,
        widthWord = 2'd3
    } accessWidth_t;

    typedef enum logic [1:0] {
        ownNone,
        ownFetch,
        ownData
    } ctrlOwner_t;

    typedef struct packed {
        logic                    en;
        logic [ramAddrWidth-1:0] addr;
    } fetchReq_t;

    typedef struct packed {
        logic                    en;
        lsOp_t                   op;
        accessWidth_t            width;
        logic [ramAddrWidth-1:0] addr;
        logic [xlen-1:0]         wdata;
    } dataReq_t;

    typedef struct packed {
        logic                    write;
        logic [ramAddrWidth-1:0] addr;
        logic [7:0]              wdata;
    } ramPort_t;

    // external request, valid is a single-cycle strobe
    typedef struct packed {
        logic                    valid;
        lsOp_t                   op;
        accessWidth_t            width;
        logic                    signExt;
        logic [ramAddrWidth-1:0] addr;
        logic [xlen-1:0]         wdata;
    } lsuCmd_t;

endpackage

// ==== hw/byteRam.sv ====
`timescale 1ns/1ns

module byteRam (
    input  logic             clk,
    input  memPkg::ramPort_t port,
    output logic [7:0]       rdata
);
    import memPkg::*;

    logic [7:0] mem [0:ramBytes-1];

    // contents start at zero
    initial begin
        for (int i = 0; i < ramBytes; i++) begin
            mem[i] = 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (port.write) begin
            mem[port.addr] <= port.wdata;
        end
        rdata <= mem[port.addr];
    end

    writeAddrInRange: assert property (
        @(posedge clk) port.write |-> !$isunknown(port.addr) && (int'(port.addr) < ramBytes)
    ) else $error("byteRam: write address %0h out of range", port.addr);

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/1ns

module memCtrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,
    input  memPkg::fetchReq_t    fetchReq,
    input  memPkg::dataReq_t     dataReq,
    input  logic [7:0]           ramRdata,
    output memPkg::ramPort_t     ramPort,
    output memPkg::ctrlOwner_t   owner,
    output logic                 fetchDone,
    output logic                 dataDone,
    output logic [31:0]          fetchInst,
    output logic [31:0]          dataRdata
);
    import memPkg::*;

    logic hold;

    // access state latched at grant
    logic [2:0]              stage;
    logic [2:0]              lastStage;
    logic [ramAddrWidth-1:0] base;
    lsOp_t                   curOp;
    logic [xlen-1:0]         assembly;

    logic            isRead;
    logic            isStore;
    logic            readLast;
    logic            storeLast;
    logic [2:0]      rdIdx;
    logic [xlen-1:0] completeWord;

    assign hold = !rdy || ioBufferFull;

    assign isRead  = (owner == ownFetch) || (owner == ownData && curOp == opLoad);
    assign isStore = (owner == ownData) && (curOp == opStore);

    // reads finish one stage after the last address, stores on the last write
    assign readLast  = isRead && (stage == lastStage + 3'd1);
    assign storeLast = isStore && (stage == lastStage);

    assign fetchDone = !hold && readLast && (owner == ownFetch);
    assign dataDone  = !hold && ((readLast && owner == ownData) || storeLast);

    // under hold keep re-reading the previous byte so rdata stays valid
    assign rdIdx = hold ? stage - 3'd1 : stage;

    always_comb begin
        ramPort.write = isStore && !hold;
        ramPort.addr  = base + ramAddrWidth'(rdIdx);
        ramPort.wdata = dataReq.wdata[8*stage[1:0] +: 8];
    end

    // last byte comes straight from the RAM output register
    always_comb begin
        completeWord = assembly;
        completeWord[8*lastStage[1:0] +: 8] = ramRdata;
    end

    assign fetchInst = completeWord;
    assign dataRdata = completeWord;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= ownNone;
            stage <= 3'd0;
        end else if (!hold) begin
            if (owner == ownNone) begin
                stage <= 3'd0;
                // data side has priority
                if (dataReq.en) begin
                    owner <= ownData;
                end else if (fetchReq.en) begin
                    owner <= ownFetch;
                end
            end else if (readLast || storeLast) begin
                owner <= ownNone;
                stage <= 3'd0;
            end else begin
                stage <= stage + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            if (owner == ownNone) begin
                assembly <= '0;
                if (dataReq.en) begin
                    base      <= dataReq.addr;
                    curOp     <= dataReq.op;
                    lastStage <= {1'b0, dataReq.width};
                end else begin
                    base      <= fetchReq.addr;
                    curOp     <= opLoad;
                    lastStage <= 3'(instBytes - 1);
                end
            end else if (isRead && stage != 3'd0 && !readLast) begin
                // byte for address base+stage-1 arrives now
                assembly[8*(stage[1:0] - 2'd1) +: 8] <= ramRdata;
            end
        end
    end

    oneDonePerCycle: assert property (
        @(posedge clk) disable iff (rst) !(fetchDone && dataDone)
    ) else $error("memCtrl: fetchDone and dataDone in the same cycle");

    writeOnlyWhenOwned: assert property (
        @(posedge clk) disable iff (rst)
        (owner != ownData || !rdy || ioBufferFull) |-> !ramPort.write
    ) else $error("memCtrl: RAM write outside a data access or under hold");

endmodule

// ==== hw/fetchUnit.sv ====
`timescale 1ns/1ns

module fetchUnit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              redirect,
    input  logic [memPkg::ramAddrWidth-1:0]   target,
    input  memPkg::ctrlOwner_t                owner,
    input  logic                              fetchDone,
    input  logic [31:0]                       fetchInst,
    output memPkg::fetchReq_t                 fetchReq,
    output logic                              instValid,
    output logic [31:0]                       inst,
    output logic [memPkg::ramAddrWidth-1:0]   instPc
);
    import memPkg::*;

    logic [ramAddrWidth-1:0] pc;
    logic                    discard;

    assign fetchReq.en   = 1'b1;
    assign fetchReq.addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc        <= '0;
            discard   <= 1'b0;
            instValid <= 1'b0;
        end else if (redirect) begin
            pc        <= target;
            instValid <= 1'b0;
            // a grant may be taking the old pc this very cycle
            discard   <= (owner == ownFetch && !fetchDone) || (owner == ownNone);
        end else if (fetchDone) begin
            if (discard) begin
                discard   <= 1'b0;
                instValid <= 1'b0;
            end else begin
                pc        <= pc + ramAddrWidth'(instBytes);
                instValid <= 1'b1;
            end
        end else begin
            instValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone) begin
            inst   <= fetchInst;
            instPc <= pc;
        end
    end

endmodule

// ==== hw/loadStoreUnit.sv ====
`timescale 1ns/1ns

module loadStoreUnit (
    input  logic               clk,
    input  logic               rst,
    input  memPkg::lsuCmd_t    cmd,
    input  logic               dataDone,
    input  logic [31:0]        dataRdata,
    output memPkg::dataReq_t   dataReq,
    output logic               busy,
    output logic               rspValid,
    output logic [31:0]        rdata
);
    import memPkg::*;

    lsuCmd_t         curCmd;
    logic            accept;
    logic [xlen-1:0] extended;

    // commands arriving while busy are dropped
    assign accept = cmd.valid && !busy;

    always_comb begin
        dataReq.en    = busy;
        dataReq.op    = curCmd.op;
        dataReq.width = curCmd.width;
        dataReq.addr  = curCmd.addr;
        dataReq.wdata = curCmd.wdata;
    end

    always_comb begin
        case (curCmd.width)
            widthByte: extended = {{(xlen-8){curCmd.signExt & dataRdata[7]}}, dataRdata[7:0]};
            widthHalf: extended = {{(xlen-16){curCmd.signExt & dataRdata[15]}},
                                   dataRdata[15:0]};
            default:   extended = dataRdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            rspValid <= busy && dataDone;
            if (accept) begin
                busy <= 1'b1;
            end else if (dataDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            curCmd <= cmd;
        end
        if (dataDone) begin
            rdata <= extended;
        end
    end

    reqFollowsBusy: assert property (
        @(posedge clk) disable iff (rst) dataReq.en == busy
    ) else $error("loadStoreUnit: dataReq.en differs from busy");

endmodule

// ==== hw/memSystem.sv ====
`timescale 1ns/1ns

module memSystem (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              ioBufferFull,
    input  logic                              redirect,
    input  logic [memPkg::ramAddrWidth-1:0]   target,
    input  memPkg::lsuCmd_t                   cmd,
    output logic                              instValid,
    output logic [memPkg::xlen-1:0]           inst,
    output logic [memPkg::ramAddrWidth-1:0]   instPc,
    output logic                              busy,
    output logic                              rspValid,
    output logic [memPkg::xlen-1:0]           rdata
);
    import memPkg::*;

    fetchReq_t       fetchReq;
    dataReq_t        dataReq;
    ramPort_t        ramPort;
    logic [7:0]      ramRdata;
    ctrlOwner_t      owner;
    logic            fetchDone;
    logic            dataDone;
    logic [xlen-1:0] fetchInst;
    logic [xlen-1:0] dataRdata;

    byteRam ram (
        .clk   (clk),
        .port  (ramPort),
        .rdata (ramRdata)
    );

    memCtrl ctrl (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .fetchReq     (fetchReq),
        .dataReq      (dataReq),
        .ramRdata     (ramRdata),
        .ramPort      (ramPort),
        .owner        (owner),
        .fetchDone    (fetchDone),
        .dataDone     (dataDone),
        .fetchInst    (fetchInst),
        .dataRdata    (dataRdata)
    );

    fetchUnit fetch (
        .clk       (clk),
        .rst       (rst),
        .redirect  (redirect),
        .target    (target),
        .owner     (owner),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .fetchReq  (fetchReq),
        .instValid (instValid),
        .inst      (inst),
        .instPc    (instPc)
    );

    loadStoreUnit lsu (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .dataDone  (dataDone),
        .dataRdata (dataRdata),
        .dataReq   (dataReq),
        .busy      (busy),
        .rspValid  (rspValid),
        .rdata     (rdata)
    );

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
    parameter int period = 40,
    parameter int resetCycles = 4,
    parameter int driveDelay = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // released just after the edge that closes the last reset cycle
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rst = 1'b0;
    end

endmodule

// ==== testbench/memSystemTb.sv ====
`timescale 1ns/1ns

module memSystemTb;
    import memPkg::*;

    localparam int clkPeriod = 40;
    localparam int driveDelay = 2;
    localparam int watchdogCycles = 2000;
    localparam int waitLimit = 150;

    logic                    clk;
    logic                    rst;
    logic                    rdy;
    logic                    ioBufferFull;
    logic                    redirect;
    logic [ramAddrWidth-1:0] target;
    lsuCmd_t                 cmd;
    logic                    instValid;
    logic [xlen-1:0]         inst;
    logic [ramAddrWidth-1:0] instPc;
    logic                    busy;
    logic                    rspValid;
    logic [xlen-1:0]         rdata;

    // reference copy of the RAM starting at zero like the RAM itself
    logic [7:0] shadow [0:ramBytes-1] = '{default: 8'h00};

    lsuCmd_t                 pendCmd;
    int                      errorCount = 0;
    int                      seqErrors = 0;
    int                      acceptCount = 0;
    int                      rspCount = 0;
    int                      instCount = 0;
    logic                    holdEnable = 1'b0;
    logic                    expectRedirect = 1'b0;
    logic [ramAddrWidth-1:0] redirectPc = '0;
    // first fetch after reset is at pc 0
    logic [ramAddrWidth-1:0] prevPc = -ramAddrWidth'(4);
    logic                    cmdSeen = 1'b0;

    tbClock #(.period(clkPeriod), .resetCycles(4), .driveDelay(driveDelay)) clockGen (
        .clk (clk),
        .rst (rst)
    );

    memSystem dut (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .redirect     (redirect),
        .target       (target),
        .cmd          (cmd),
        .instValid    (instValid),
        .inst         (inst),
        .instPc       (instPc),
        .busy         (busy),
        .rspValid     (rspValid),
        .rdata        (rdata)
    );

    // little-endian word from the reference copy
    function automatic logic [xlen-1:0] shadowWord(input logic [ramAddrWidth-1:0] addr);
        logic [xlen-1:0] word;
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = shadow[addr + ramAddrWidth'(i)];
        end
        return word;
    endfunction

    function automatic logic [xlen-1:0] expectedLoad(input logic [ramAddrWidth-1:0] addr,
                                                     input accessWidth_t width,
                                                     input logic signExt);
        int              count;
        logic [xlen-1:0] value;
        count = int'(width) + 1;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value[8*i +: 8] = shadow[addr + ramAddrWidth'(i)];
        end
        // top loaded bit fills the upper bytes
        if (signExt && count < 4 && value[8*count-1]) begin
            for (int i = count; i < 4; i++) begin
                value[8*i +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    function automatic accessWidth_t randomWidth();
        case ($urandom % 3)
            0:       return widthByte;
            1:       return widthHalf;
            default: return widthWord;
        endcase
    endfunction

    task automatic reportValue(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        errorCount++;
        $display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic writeShadow(input lsuCmd_t c);
        for (int i = 0; i <= int'(c.width); i++) begin
            shadow[c.addr + ramAddrWidth'(i)] = c.wdata[8*i +: 8];
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #driveDelay;
    endtask

    // registered outputs have settled by the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (instValid) begin
                instCount++;
                assert (inst == shadowWord(instPc))
                    else reportValue("inst", shadowWord(instPc), inst);
                if (expectRedirect) begin
                    assert (instPc == redirectPc)
                        else reportValue("instPc", xlen'(redirectPc), xlen'(instPc));
                end else begin
                    assert (instPc == prevPc + ramAddrWidth'(4))
                        else reportValue("instPc", xlen'(prevPc + ramAddrWidth'(4)),
                                         xlen'(instPc));
                end
                expectRedirect = 1'b0;
                prevPc = instPc;
            end
            if (redirect) begin
                expectRedirect = 1'b1;
                redirectPc = target;
            end
            // a command taken while idle shows up as busy one cycle later
            if (cmdSeen) begin
                assert (busy) else reportValue("busy", xlen'(1), xlen'(busy));
            end
            cmdSeen = cmd.valid && !busy;
            if (rspValid) begin
                assert (rspCount < acceptCount) else begin
                    errorCount++;
                    $display("failure at %0t ns: response without an accepted command", $time);
                end
                if (pendCmd.op == opStore) begin
                    writeShadow(pendCmd);
                end else begin
                    assert (rdata == expectedLoad(pendCmd.addr, pendCmd.width, pendCmd.signExt))
                        else reportValue("rdata",
                                         expectedLoad(pendCmd.addr, pendCmd.width,
                                                      pendCmd.signExt), rdata);
                end
                rspCount++;
            end
        end
    end

    task automatic runCmd(input lsOp_t op, input accessWidth_t width, input logic signExt,
                          input logic [ramAddrWidth-1:0] addr, input logic [xlen-1:0] wdata,
                          input logic extraPulse);
        int waited;
        while (busy) begin
            stepCycle();
        end
        cmd.valid = 1'b1;
        cmd.op = op;
        cmd.width = width;
        cmd.signExt = signExt;
        cmd.addr = addr;
        cmd.wdata = wdata;
        pendCmd = cmd;
        acceptCount++;
        stepCycle();
        cmd.valid = 1'b0;
        // the unit is busy now so this pulse must be dropped
        if (extraPulse) begin
            cmd.valid = 1'b1;
            cmd.addr = ~addr;
            cmd.wdata = ~wdata;
            stepCycle();
            cmd.valid = 1'b0;
        end
        waited = 0;
        while (rspCount != acceptCount && waited < waitLimit) begin
            stepCycle();
            waited++;
        end
        if (rspCount != acceptCount) begin
            seqErrors++;
            $display("failure at %0t ns: no response to a load/store command", $time);
        end
    endtask

    task automatic redirectTo(input logic [ramAddrWidth-1:0] pc);
        int startCount;
        int waited;
        redirect = 1'b1;
        target = pc;
        stepCycle();
        redirect = 1'b0;
        startCount = instCount;
        waited = 0;
        while (instCount < startCount + 2 && waited < waitLimit) begin
            stepCycle();
            waited++;
        end
        if (instCount < startCount + 2) begin
            seqErrors++;
            $display("failure at %0t ns: no instructions after a redirect", $time);
        end
    endtask

    // random holds on the two freeze inputs
    initial begin
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        forever begin
            stepCycle();
            if (holdEnable) begin
                rdy = ($urandom % 4) != 0;
                ioBufferFull = ($urandom % 5) == 0;
            end else begin
                rdy = 1'b1;
                ioBufferFull = 1'b0;
            end
        end
    end

    initial begin
        logic [31:0]             seedEcho;
        logic [ramAddrWidth-1:0] addr;
        logic [ramAddrWidth-1:0] lastAddr;
        logic [xlen-1:0]         data;
        accessWidth_t            width;
        lsOp_t                   op;
        seedEcho = $urandom(32'h74e4);
        redirect = 1'b0;
        target = '0;
        cmd = '0;
        lastAddr = '0;
        @(negedge rst);

        // word store then word load
        for (int n = 0; n < 6; n++) begin
            addr = ramAddrWidth'($urandom);
            addr[1:0] = 2'b00;
            data = $urandom;
            runCmd(opStore, widthWord, 1'b0, addr, data, 1'b0);
            runCmd(opLoad, widthWord, 1'b0, addr, '0, 1'b0);
        end

        for (int n = 0; n < 8; n++) begin
            addr = ramAddrWidth'($urandom);
            data = $urandom;
            width = ($urandom % 2 == 0) ? widthByte : widthHalf;
            runCmd(opStore, width, 1'b0, addr, data, n[0]);
            runCmd(opLoad, width, 1'b1, addr, '0, 1'b0);
            runCmd(opLoad, width, 1'b0, addr, '0, 1'b0);
        end

        holdEnable = 1'b1;
        for (int n = 0; n < 16; n++) begin
            op = ($urandom % 2 == 0) ? opStore : opLoad;
            addr = ramAddrWidth'($urandom);
            // loads go back to recently written bytes
            if (op == opStore) begin
                lastAddr = addr;
            end else begin
                addr = lastAddr + ramAddrWidth'($urandom % 4);
            end
            runCmd(op, randomWidth(), 1'($urandom), addr, $urandom, ($urandom % 3) == 0);
        end

        for (int n = 0; n < 3; n++) begin
            addr = ramAddrWidth'($urandom);
            addr[1:0] = 2'b00;
            runCmd(opStore, widthWord, 1'b0, addr, $urandom, 1'b0);
            runCmd(opStore, widthWord, 1'b0, addr + ramAddrWidth'(4), $urandom, 1'b0);
            redirectTo(addr);
        end

        holdEnable = 1'b0;
        repeat (4) stepCycle();
        assert (rspCount == acceptCount) else begin
            seqErrors++;
            $display("failure: %0d commands accepted but %0d responses seen",
                     acceptCount, rspCount);
        end
        $display("errors: %0d value, %0d sequence; commands %0d, responses %0d, instructions %0d",
                 errorCount, seqErrors, acceptCount, rspCount, instCount);
        if (errorCount + seqErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("failure at %0t ns: watchdog expired after %0d cycles", $time, watchdogCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
hw/memPkg.sv
hw/byteRam.sv
hw/memCtrl.sv
hw/fetchUnit.sv
hw/loadStoreUnit.sv
hw/memSystem.sv
testbench/tbClock.sv
testbench/memSystemTb.sv

// ==== Makefile ====
TOP := memSystemTb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
